// ==== src/sdar_pkg.sv ====
package sdar_pkg;

	// stream widths
	localparam int AXIS_DATA_W = 256;
	localparam int AXIS_KEEP_W = AXIS_DATA_W / 8;
	localparam int AXIS_USER_W = 128;
	localparam int SAMPLE_W    = 32;
	localparam int REG_ADDR_W  = 4;
	localparam int REG_DATA_W  = 32;

	typedef logic [AXIS_DATA_W-1:0] axis_data_t;
	typedef logic [AXIS_KEEP_W-1:0] axis_keep_t;
	typedef logic [AXIS_USER_W-1:0] axis_user_t;
	typedef logic [SAMPLE_W-1:0]    sample_t;
	typedef logic [SAMPLE_W-1:0]    score_t;
	typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
	typedef logic [REG_DATA_W-1:0]  reg_data_t;

	// one beat, valid and ready travel separately
	typedef struct packed {
		axis_data_t tdata;
		axis_keep_t tkeep;
		axis_user_t tuser;
		logic       tlast;
	} axis_beat_t;

	typedef enum logic [1:0] {
		SCORE_IDLE,
		SCORE_LOAD,
		SCORE_COMPUTE
	} score_state_e;

	// header field offsets, bit positions within a beat
	localparam int ETH_TYPE_POS     = 96;
	localparam int IP_PROTO_POS     = 184;
	// these two are in the second beat
	localparam int UDP_DST_PORT_POS = 32;
	localparam int USER_DATA_POS    = 80;

	// ethertype 0x0800 with the bytes as seen on the bus
	localparam logic [15:0] IP_TYPE_SWAPPED = 16'h0008;
	localparam logic [7:0]  UDP_PROTO       = 8'h11;
	localparam logic [15:0] UDP_PORT_TRIG   = 16'd12345;

	// register map
	localparam reg_addr_t REG_ID     = 4'd0;
	localparam reg_addr_t REG_RESULT = 4'd1;
	localparam reg_addr_t REG_TPUT   = 4'd2;
	localparam reg_addr_t REG_PKTIN  = 4'd3;
	localparam reg_addr_t REG_PKTOUT = 4'd4;
	localparam reg_addr_t REG_DROP   = 4'd5;
	localparam reg_addr_t REG_CTRL   = 4'd6;

	// ctrl write bits
	localparam int CTRL_CLR_CNT_BIT    = 0;
	localparam int CTRL_CLR_RESULT_BIT = 1;
	localparam int CTRL_CLR_MODE_BIT   = 2;

	localparam reg_data_t ID_VALUE = 32'h5da2_0100;

endpackage

// ==== src/udp_trigger_parser.sv ====
`timescale 1ns/1ps

module udp_trigger_parser (
	input  logic                 axis_aclk,
	input  logic                 cf_rstn,
	input  sdar_pkg::axis_beat_t beat_i,
	input  logic                 beat_fire_i,
	output logic                 sample_valid_o,
	output sdar_pkg::sample_t    sample_value_o
);

	import sdar_pkg::*;

	// beat index inside the packet saturating at 2
	logic [1:0]  beat_cnt;
	logic        is_ip;
	logic        is_udp;
	logic        eth_is_ip;
	logic        proto_is_udp;
	logic [15:0] dst_port;
	logic        port_hit;
	logic        trigger;

	// first beat fields
	assign eth_is_ip    = beat_i.tdata[ETH_TYPE_POS +: 16] == IP_TYPE_SWAPPED;
	assign proto_is_udp = beat_i.tdata[IP_PROTO_POS +: 8] == UDP_PROTO;

	// port arrives in network order so the two bytes are swapped
	assign dst_port = {beat_i.tdata[UDP_DST_PORT_POS +: 8],
		beat_i.tdata[UDP_DST_PORT_POS+8 +: 8]};
	assign port_hit = dst_port == UDP_PORT_TRIG;

	assign trigger = beat_fire_i && (beat_cnt == 2'd1) && is_ip && is_udp && port_hit;

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			beat_cnt <= 2'd0;
			is_ip    <= 1'b0;
			is_udp   <= 1'b0;
		end else if (beat_fire_i) begin
			if (beat_i.tlast) begin
				// end of packet resets the header state
				beat_cnt <= 2'd0;
				is_ip    <= 1'b0;
				is_udp   <= 1'b0;
			end else begin
				if (beat_cnt == 2'd0) begin
					is_ip  <= eth_is_ip;
					is_udp <= proto_is_udp;
				end
				if (beat_cnt != 2'd2) begin
					beat_cnt <= beat_cnt + 2'd1;
				end
			end
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			sample_valid_o <= 1'b0;
		end else begin
			sample_valid_o <= trigger;
		end
	end

	// user value of the matching packet
	always_ff @(posedge axis_aclk) begin
		if (trigger) begin
			sample_value_o <= beat_i.tdata[USER_DATA_POS +: SAMPLE_W];
		end
	end

endmodule

// ==== src/sample_fifo.sv ====
`timescale 1ns/1ps

module sample_fifo #(
	parameter int unsigned FIFO_DEPTH_BITS = 3
) (
	input  logic              axis_aclk,
	input  logic              cf_rstn,
	input  logic              wr_i,
	input  sdar_pkg::sample_t din_i,
	input  logic              rd_i,
	output sdar_pkg::sample_t dout_o,
	output logic              empty_o,
	output logic              full_o,
	output logic              drop_o
);

	import sdar_pkg::*;

	localparam int unsigned DEPTH = 1 << FIFO_DEPTH_BITS;

	sample_t mem [DEPTH];

	// one extra bit tells full from empty
	logic [FIFO_DEPTH_BITS:0] wr_ptr;
	logic [FIFO_DEPTH_BITS:0] rd_ptr;
	logic                     do_wr;
	logic                     do_rd;

	assign empty_o = wr_ptr == rd_ptr;
	assign full_o  = (wr_ptr[FIFO_DEPTH_BITS] != rd_ptr[FIFO_DEPTH_BITS]) &&
		(wr_ptr[FIFO_DEPTH_BITS-1:0] == rd_ptr[FIFO_DEPTH_BITS-1:0]);

	assign do_wr = wr_i && !full_o;
	assign do_rd = rd_i && !empty_o;

	// head of queue, shown without a read
	assign dout_o = mem[rd_ptr[FIFO_DEPTH_BITS-1:0]];

	always_ff @(posedge axis_aclk) begin
		if (do_wr) begin
			mem[wr_ptr[FIFO_DEPTH_BITS-1:0]] <= din_i;
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			drop_o <= 1'b0;
		end else begin
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// sample refused, flag it once
			drop_o <= wr_i && full_o;
		end
	end

endmodule

// ==== src/sdar_score_core.sv ====
`timescale 1ns/1ps

module sdar_score_core #(
	parameter int unsigned FORGET_SHIFT = 5
) (
	input  logic              axis_aclk,
	input  logic              cf_rstn,
	input  logic              empty_i,
	input  sdar_pkg::sample_t din_i,
	output logic              pop_o,
	input  logic              mode_clear_i,
	output logic              score_valid_o,
	output sdar_pkg::score_t  score_o
);

	import sdar_pkg::*;

	score_state_e state;
	score_state_e state_next;

	sample_t sample_q;
	score_t  mean_q;
	score_t  score_q;
	// next sample only seeds the mean
	logic    first_q;

	logic signed [32:0] diff;
	logic signed [32:0] diff_abs;
	logic signed [32:0] step;
	logic signed [32:0] mean_sum;

	// pop from idle, or straight away when a score goes out
	assign pop_o = ((state == SCORE_IDLE) || (state == SCORE_COMPUTE)) && !empty_i;

	assign score_valid_o = state == SCORE_COMPUTE;
	assign score_o       = score_q;

	always_comb begin
		state_next = state;
		case (state)
			SCORE_IDLE:    state_next = empty_i ? SCORE_IDLE : SCORE_LOAD;
			SCORE_LOAD:    state_next = SCORE_COMPUTE;
			SCORE_COMPUTE: state_next = empty_i ? SCORE_IDLE : SCORE_LOAD;
			default:       state_next = SCORE_IDLE;
		endcase
	end

	// deviation and discounted step toward the sample
	always_comb begin
		diff     = $signed({1'b0, sample_q}) - $signed({1'b0, mean_q});
		diff_abs = diff[32] ? -diff : diff;
		step     = diff >>> FORGET_SHIFT;
		mean_sum = $signed({1'b0, mean_q}) + step;
	end

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			state   <= SCORE_IDLE;
			first_q <= 1'b1;
		end else begin
			state <= state_next;
			if (mode_clear_i) begin
				first_q <= 1'b1;
			end else if (state == SCORE_LOAD) begin
				first_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge axis_aclk) begin
		if (pop_o) begin
			sample_q <= din_i;
		end
		if (state == SCORE_LOAD) begin
			if (first_q) begin
				mean_q  <= sample_q;
				score_q <= '0;
			end else begin
				// result stays between mean and sample, so 32 bits hold it
				mean_q  <= mean_sum[31:0];
				score_q <= diff_abs[31:0];
			end
		end
	end

endmodule

// ==== src/sdar_stats_regs.sv ====
`timescale 1ns/1ps

module sdar_stats_regs (
	input  logic                axis_aclk,
	input  logic                cf_rstn,
	input  logic                score_valid_i,
	input  sdar_pkg::score_t    score_i,
	input  logic                drop_i,
	input  logic                pkt_in_i,
	input  logic                pkt_out_i,
	input  logic                reg_wr_i,
	input  logic                reg_rd_i,
	input  sdar_pkg::reg_addr_t reg_addr_i,
	input  sdar_pkg::reg_data_t reg_wdata_i,
	output sdar_pkg::reg_data_t reg_rdata_o,
	output logic                mode_clear_o
);

	import sdar_pkg::*;

	score_t    result_q;
	reg_data_t tput_q;
	reg_data_t pktin_q;
	reg_data_t pktout_q;
	reg_data_t drop_q;

	logic ctrl_wr;
	logic clr_cnt;
	logic clr_result;

	// low 31 bits wrap, bit 31 remembers that it happened
	function automatic reg_data_t sat_inc(input reg_data_t cnt, input logic inc);
		reg_data_t nxt;
		nxt = cnt;
		if (inc) begin
			nxt[30:0] = cnt[30:0] + 31'd1;
			if (&cnt[30:0]) begin
				nxt[31] = 1'b1;
			end
		end
		return nxt;
	endfunction

	assign ctrl_wr    = reg_wr_i && (reg_addr_i == REG_CTRL);
	assign clr_cnt    = ctrl_wr && reg_wdata_i[CTRL_CLR_CNT_BIT];
	assign clr_result = ctrl_wr && reg_wdata_i[CTRL_CLR_RESULT_BIT];

	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			result_q     <= '0;
			tput_q       <= '0;
			pktin_q      <= '0;
			pktout_q     <= '0;
			drop_q       <= '0;
			mode_clear_o <= 1'b0;
		end else begin
			mode_clear_o <= ctrl_wr && reg_wdata_i[CTRL_CLR_MODE_BIT];

			if (clr_result) begin
				result_q <= '0;
			end else if (score_valid_i) begin
				result_q <= score_i;
			end

			if (clr_cnt) begin
				tput_q   <= '0;
				pktin_q  <= '0;
				pktout_q <= '0;
				drop_q   <= '0;
			end else begin
				tput_q   <= tput_q + reg_data_t'(score_valid_i);
				drop_q   <= drop_q + reg_data_t'(drop_i);
				pktin_q  <= sat_inc(pktin_q, pkt_in_i);
				pktout_q <= sat_inc(pktout_q, pkt_out_i);
			end
		end
	end

	// read data holds until the next read
	always_ff @(posedge axis_aclk) begin
		if (!cf_rstn) begin
			reg_rdata_o <= '0;
		end else if (reg_rd_i) begin
			case (reg_addr_i)
				REG_ID:     reg_rdata_o <= ID_VALUE;
				REG_RESULT: reg_rdata_o <= result_q;
				REG_TPUT:   reg_rdata_o <= tput_q;
				REG_PKTIN:  reg_rdata_o <= pktin_q;
				REG_PKTOUT: reg_rdata_o <= pktout_q;
				REG_DROP:   reg_rdata_o <= drop_q;
				default:    reg_rdata_o <= '0;
			endcase
		end
	end

endmodule

// ==== src/sdar_top.sv ====
`timescale 1ns/1ps

module sdar_top #(
	parameter int unsigned FIFO_DEPTH_BITS = 3,
	parameter int unsigned FORGET_SHIFT    = 5
) (
	input  logic                 axis_aclk,
	input  logic                 cf_rstn,

	input  sdar_pkg::axis_beat_t s_axis_beat_i,
	input  logic                 s_axis_tvalid_i,
	output logic                 s_axis_tready_o,

	output sdar_pkg::axis_beat_t m_axis_beat_o,
	output logic                 m_axis_tvalid_o,
	input  logic                 m_axis_tready_i,

	input  logic                 reg_wr_i,
	input  logic                 reg_rd_i,
	input  sdar_pkg::reg_addr_t  reg_addr_i,
	input  sdar_pkg::reg_data_t  reg_wdata_i,
	output sdar_pkg::reg_data_t  reg_rdata_o
);

	import sdar_pkg::*;

	logic    beat_fire;
	logic    pkt_in;
	logic    pkt_out;

	logic    sample_valid;
	sample_t sample_value;
	logic    fifo_empty;
	sample_t fifo_dout;
	logic    fifo_pop;
	logic    drop;
	logic    score_valid;
	score_t  score_value;
	logic    mode_clear;

	// stream and back-pressure pass straight through
	assign m_axis_beat_o   = s_axis_beat_i;
	assign m_axis_tvalid_o = s_axis_tvalid_i;
	assign s_axis_tready_o = m_axis_tready_i;

	assign beat_fire = s_axis_tvalid_i && s_axis_tready_o;
	assign pkt_in    = beat_fire && s_axis_beat_i.tlast;
	assign pkt_out   = m_axis_tvalid_o && m_axis_tready_i && m_axis_beat_o.tlast;

	udp_trigger_parser i_parser (
		.axis_aclk      (axis_aclk),
		.cf_rstn        (cf_rstn),
		.beat_i         (s_axis_beat_i),
		.beat_fire_i    (beat_fire),
		.sample_valid_o (sample_valid),
		.sample_value_o (sample_value)
	);

	sample_fifo #(
		.FIFO_DEPTH_BITS (FIFO_DEPTH_BITS)
	) i_fifo (
		.axis_aclk (axis_aclk),
		.cf_rstn   (cf_rstn),
		.wr_i      (sample_valid),
		.din_i     (sample_value),
		.rd_i      (fifo_pop),
		.dout_o    (fifo_dout),
		.empty_o   (fifo_empty),
		.full_o    (),
		.drop_o    (drop)
	);

	sdar_score_core #(
		.FORGET_SHIFT (FORGET_SHIFT)
	) i_core (
		.axis_aclk     (axis_aclk),
		.cf_rstn       (cf_rstn),
		.empty_i       (fifo_empty),
		.din_i         (fifo_dout),
		.pop_o         (fifo_pop),
		.mode_clear_i  (mode_clear),
		.score_valid_o (score_valid),
		.score_o       (score_value)
	);

	sdar_stats_regs i_stats (
		.axis_aclk     (axis_aclk),
		.cf_rstn       (cf_rstn),
		.score_valid_i (score_valid),
		.score_i       (score_value),
		.drop_i        (drop),
		.pkt_in_i      (pkt_in),
		.pkt_out_i     (pkt_out),
		.reg_wr_i      (reg_wr_i),
		.reg_rd_i      (reg_rd_i),
		.reg_addr_i    (reg_addr_i),
		.reg_wdata_i   (reg_wdata_i),
		.reg_rdata_o   (reg_rdata_o),
		.mode_clear_o  (mode_clear)
	);

endmodule

// ==== tb/sdar_checker.sv ====
`timescale 1ns/1ps

module sdar_checker (
	input logic                 axis_aclk,
	input logic                 cf_rstn,
	input sdar_pkg::axis_beat_t s_beat_i,
	input logic                 s_tvalid_i,
	input logic                 s_tready_i,
	input sdar_pkg::axis_beat_t m_beat_i,
	input logic                 m_tvalid_i,
	input logic                 m_tready_i,
	input logic                 fifo_empty_i,
	input logic                 fifo_pop_i,
	input logic                 score_valid_i,
	input logic                 sample_valid_i,
	input logic                 drop_i,
	input logic                 mode_clear_i
);

	// read by the testbench to end the run
	int unsigned fail_cnt = 0;

	// stream wires through untouched
	a_passthrough: assert property (@(posedge axis_aclk)
		(m_beat_i == s_beat_i) && (m_tvalid_i == s_tvalid_i) && (s_tready_i == m_tready_i))
	else begin
		fail_cnt++;
		$error("stream output differs from stream input");
	end

	a_pop_not_empty: assert property (@(posedge axis_aclk) disable iff (!cf_rstn)
		fifo_pop_i |-> !fifo_empty_i)
	else begin
		fail_cnt++;
		$error("sample FIFO popped while empty");
	end

	// load, then compute
	a_pop_to_score: assert property (@(posedge axis_aclk) disable iff (!cf_rstn)
		fifo_pop_i |-> ##2 score_valid_i)
	else begin
		fail_cnt++;
		$error("score_valid not seen 2 cycles after fifo_pop");
	end

	// first edge in reset still shows power-up values
	a_quiet_in_reset: assert property (@(posedge axis_aclk)
		(!cf_rstn && !$past(cf_rstn)) |->
		!(sample_valid_i || fifo_pop_i || score_valid_i || drop_i || mode_clear_i))
	else begin
		fail_cnt++;
		$error("control strobe high during reset");
	end

endmodule

bind sdar_top sdar_checker i_checker (
	.axis_aclk      (axis_aclk),
	.cf_rstn        (cf_rstn),
	.s_beat_i       (s_axis_beat_i),
	.s_tvalid_i     (s_axis_tvalid_i),
	.s_tready_i     (s_axis_tready_o),
	.m_beat_i       (m_axis_beat_o),
	.m_tvalid_i     (m_axis_tvalid_o),
	.m_tready_i     (m_axis_tready_i),
	.fifo_empty_i   (fifo_empty),
	.fifo_pop_i     (fifo_pop),
	.score_valid_i  (score_valid),
	.sample_valid_i (sample_valid),
	.drop_i         (drop),
	.mode_clear_i   (mode_clear)
);

// ==== tb/sdar_tb.sv ====
`timescale 1ns/1ps

module sdar_tb;

	import sdar_pkg::*;

	localparam int     CLK_PERIOD   = 40;
	localparam int     FORGET_SHIFT = 5;
	localparam longint DISCOUNT     = longint'(1) << FORGET_SHIFT;
	localparam int     N_TRIG       = 8;
	localparam int     N_BURST      = 12;
	localparam int     N_PKTS       = 2 * N_TRIG + 2 + N_BURST;
	localparam int     WATCHDOG_NS  = (N_PKTS * 20 + 200) * CLK_PERIOD;
	localparam int     PKT_TRIGGER  = 0;
	localparam int     PKT_NOT_IP   = 1;
	localparam int     PKT_NOT_UDP  = 2;
	localparam int     PKT_BAD_PORT = 3;

	logic       axis_aclk;
	logic       cf_rstn;
	axis_beat_t s_axis_beat_i;
	logic       s_axis_tvalid_i;
	logic       s_axis_tready_o;
	axis_beat_t m_axis_beat_o;
	logic       m_axis_tvalid_o;
	logic       m_axis_tready_i;
	logic       reg_wr_i;
	logic       reg_rd_i;
	reg_addr_t  reg_addr_i;
	reg_data_t  reg_wdata_i;
	reg_data_t  reg_rdata_o;

	logic   bp_on;
	int     pkt_count;
	score_t ref_mean;
	logic   ref_first;

	sdar_top #(
		.FIFO_DEPTH_BITS (2),
		.FORGET_SHIFT    (FORGET_SHIFT)
	) i_dut (
		.axis_aclk       (axis_aclk),
		.cf_rstn         (cf_rstn),
		.s_axis_beat_i   (s_axis_beat_i),
		.s_axis_tvalid_i (s_axis_tvalid_i),
		.s_axis_tready_o (s_axis_tready_o),
		.m_axis_beat_o   (m_axis_beat_o),
		.m_axis_tvalid_o (m_axis_tvalid_o),
		.m_axis_tready_i (m_axis_tready_i),
		.reg_wr_i        (reg_wr_i),
		.reg_rd_i        (reg_rd_i),
		.reg_addr_i      (reg_addr_i),
		.reg_wdata_i     (reg_wdata_i),
		.reg_rdata_o     (reg_rdata_o)
	);

	always #(CLK_PERIOD / 2) axis_aclk = ~axis_aclk;

	// random gaps in the downstream ready
	always @(posedge axis_aclk) begin
		#2;
		m_axis_tready_i = !bp_on || ($urandom_range(3) != 0);
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_value(input string name, input reg_data_t got, input reg_data_t exp);
		assert (got === exp) else begin
			stop_with_failure($sformatf("[FAIL] time=%0t %s expected=%h actual=%h",
				$time, name, exp, got));
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge axis_aclk);
		#2;
	endtask

	task automatic read_register(input reg_addr_t addr, output reg_data_t data);
		reg_rd_i   = 1'b1;
		reg_addr_i = addr;
		idle_cycles(1);
		reg_rd_i = 1'b0;
		data     = reg_rdata_o;
	endtask

	task automatic write_register(input reg_addr_t addr, input reg_data_t data);
		reg_wr_i    = 1'b1;
		reg_addr_i  = addr;
		reg_wdata_i = data;
		idle_cycles(1);
		reg_wr_i = 1'b0;
	endtask

	// holds the beat until ready takes it
	task automatic send_beat(input axis_beat_t beat);
		s_axis_beat_i   = beat;
		s_axis_tvalid_i = 1'b1;
		@(posedge axis_aclk);
		while (!m_axis_tready_i) @(posedge axis_aclk);
		#2;
	endtask

	task automatic send_packet(input int kind, input sample_t value);
		axis_beat_t  beat;
		logic [15:0] port;
		int          nbeats;
		nbeats = 2 + $urandom_range(1);
		for (int i = 0; i < nbeats; i++) begin
			for (int w = 0; w < AXIS_DATA_W / 32; w++) beat.tdata[w*32 +: 32] = $urandom;
			beat.tkeep = '1;
			beat.tuser = {$urandom, $urandom, $urandom, $urandom};
			beat.tlast = (i == nbeats - 1);
			if (i == 0) begin
				beat.tdata[ETH_TYPE_POS +: 16] = (kind == PKT_NOT_IP) ? 16'h0608 : IP_TYPE_SWAPPED;
				beat.tdata[IP_PROTO_POS +: 8]  = (kind == PKT_NOT_UDP) ? 8'h06 : UDP_PROTO;
			end else if (i == 1) begin
				port = (kind == PKT_BAD_PORT) ? 16'd12346 : UDP_PORT_TRIG;
				// network byte order, first byte lowest on the bus
				beat.tdata[UDP_DST_PORT_POS +: 16] = {port[7:0], port[15:8]};
				beat.tdata[USER_DATA_POS +: 32]    = value;
			end
			send_beat(beat);
		end
		s_axis_tvalid_i = 1'b0;
		pkt_count++;
	endtask

	// discounted mean, step rounded toward minus infinity
	task automatic model_update(input sample_t value, output score_t score);
		longint d;
		longint step;
		if (ref_first) begin
			ref_mean  = value;
			score     = '0;
			ref_first = 1'b0;
		end else begin
			d     = longint'(value) - longint'(ref_mean);
			score = (d < 0) ? score_t'(-d) : score_t'(d);
			if (d >= 0) step = d / DISCOUNT;
			else step = -((-d + DISCOUNT - 1) / DISCOUNT);
			ref_mean = score_t'(longint'(ref_mean) + step);
		end
	endtask

	task automatic score_and_check(input sample_t value);
		reg_data_t tput_old;
		reg_data_t tput_new;
		reg_data_t result;
		score_t    exp_score;
		int        polls;
		read_register(REG_TPUT, tput_old);
		send_packet(PKT_TRIGGER, value);
		model_update(value, exp_score);
		polls    = 0;
		tput_new = tput_old;
		while (tput_new == tput_old && polls < 40) begin
			read_register(REG_TPUT, tput_new);
			polls++;
		end
		check_value("REG_TPUT", tput_new, tput_old + 1);
		read_register(REG_RESULT, result);
		check_value("REG_RESULT", result, exp_score);
	endtask

	// sample path takes a fixed few cycles, 8 covers it
	task automatic send_ignored(input int kind);
		reg_data_t tput_old;
		reg_data_t tput_new;
		read_register(REG_TPUT, tput_old);
		send_packet(kind, $urandom);
		idle_cycles(8);
		read_register(REG_TPUT, tput_new);
		check_value("REG_TPUT", tput_new, tput_old);
	endtask

	initial begin
		wait (i_dut.i_checker.fail_cnt != 0);
		stop_with_failure("a concurrent assertion in the checker failed");
	end

	initial begin
		#(WATCHDOG_NS);
		stop_with_failure("timeout: the test did not finish in time");
	end

	initial begin
		reg_data_t rd;
		reg_data_t tput0;
		reg_data_t drop0;
		reg_data_t tput;
		reg_data_t drop;
		int        polls;
		void'($urandom(32'h889251b4));
		axis_aclk       = 1'b0;
		cf_rstn         = 1'b0;
		s_axis_beat_i   = '0;
		s_axis_tvalid_i = 1'b0;
		m_axis_tready_i = 1'b1;
		reg_wr_i        = 1'b0;
		reg_rd_i        = 1'b0;
		reg_addr_i      = '0;
		reg_wdata_i     = '0;
		bp_on           = 1'b0;
		pkt_count       = 0;
		ref_mean        = '0;
		ref_first       = 1'b1;
		idle_cycles(2);
		cf_rstn = 1'b1;

		read_register(REG_ID, rd);
		check_value("REG_ID", rd, ID_VALUE);

		bp_on = 1'b1;
		for (int i = 0; i < N_TRIG; i++) begin
			send_ignored(PKT_NOT_IP + i % 3);
			score_and_check($urandom);
		end

		// reseed the mean, then clear the result
		write_register(REG_CTRL, 32'h4);
		ref_first = 1'b1;
		score_and_check($urandom);
		score_and_check($urandom);
		write_register(REG_CTRL, 32'h2);
		read_register(REG_RESULT, rd);
		check_value("REG_RESULT", rd, '0);
		read_register(REG_ID, rd);
		check_value("REG_ID", rd, ID_VALUE);

		// back-to-back triggers while the core is busy
		read_register(REG_TPUT, tput0);
		read_register(REG_DROP, drop0);
		for (int i = 0; i < N_BURST; i++) send_packet(PKT_TRIGGER, $urandom);
		polls = 0;
		do begin
			read_register(REG_TPUT, tput);
			read_register(REG_DROP, drop);
			polls++;
		end while ((tput - tput0) + (drop - drop0) < N_BURST && polls < 40);
		check_value("REG_DROP+REG_TPUT", (tput - tput0) + (drop - drop0), N_BURST);

		read_register(REG_PKTIN, rd);
		check_value("REG_PKTIN", rd, pkt_count);
		read_register(REG_PKTOUT, rd);
		check_value("REG_PKTOUT", rd, pkt_count);

		write_register(REG_CTRL, 32'h1);
		read_register(REG_TPUT, rd);
		check_value("REG_TPUT", rd, '0);
		read_register(REG_PKTIN, rd);
		check_value("REG_PKTIN", rd, '0);
		read_register(REG_PKTOUT, rd);
		check_value("REG_PKTOUT", rd, '0);
		read_register(REG_DROP, rd);
		check_value("REG_DROP", rd, '0);
		read_register(REG_ID, rd);
		check_value("REG_ID", rd, ID_VALUE);

		idle_cycles(4);
		if (i_dut.i_checker.fail_cnt != 0) begin
			stop_with_failure("a concurrent assertion in the checker failed");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

// ==== sdar_udp.f ====
src/sdar_pkg.sv
src/udp_trigger_parser.sv
src/sample_fifo.sv
src/sdar_score_core.sv
src/sdar_stats_regs.sv
src/sdar_top.sv
tb/sdar_checker.sv
tb/sdar_tb.sv

// ==== Bender.yml ====
package:
  name: sdar_udp

sources:
  - src/sdar_pkg.sv
  - src/udp_trigger_parser.sv
  - src/sample_fifo.sv
  - src/sdar_score_core.sv
  - src/sdar_stats_regs.sv
  - src/sdar_top.sv
  - target: test
    files:
      - tb/sdar_checker.sv
      - tb/sdar_tb.sv
